// ==== design/mips_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core widths, opcode and function encodings,
// ALU, operand source and branch enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mips_pkg;

	// widths
	localparam int data_width      = 32;
	localparam int reg_addr_width  = 5;
	localparam int imem_addr_width = 6; // 64 words of program

	// primary opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_addiu = 6'h09;

	// R-type function codes, instr[5:0]
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// ALU operation carried from decode to execute
	typedef enum logic [2:0] {
		alu_add  = 3'd0,
		alu_sub  = 3'd1,
		alu_and  = 3'd2,
		alu_or   = 3'd3,
		alu_xor  = 3'd4,
		alu_slt  = 3'd5, // signed compare
		alu_sll  = 3'd6, // b shifted by shamt
		alu_none = 3'd7  // no-op, result is zero
	} alu_op_t;

	// second ALU operand
	typedef enum logic {
		src_reg = 1'b0,
		src_imm = 1'b1 // sign-extended imm16
	} alu_src_t;

	typedef enum logic {
		br_none = 1'b0,
		br_beq  = 1'b1
	} branch_op_t;

	// instruction field positions
	localparam int opcode_lsb = 26;
	localparam int rs_lsb     = 21;
	localparam int rt_lsb     = 16;
	localparam int rd_lsb     = 11;
	localparam int sa_lsb     = 6;

endpackage

`default_nettype wire

// ==== design/register_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32x32 register file, two bypassed read ports
// and a debug read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module register_file (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [mips_pkg::reg_addr_width-1:0]    rd1_addr,
	input  logic [mips_pkg::reg_addr_width-1:0]    rd2_addr,
	input  logic                                   wr_en,
	input  logic [mips_pkg::reg_addr_width-1:0]    wr_addr,
	input  logic [mips_pkg::data_width-1:0]        wr_data,
	input  logic [mips_pkg::reg_addr_width-1:0]    debug_addr,
	output logic [mips_pkg::data_width-1:0]        rd1_data,
	output logic [mips_pkg::data_width-1:0]        rd2_data,
	output logic [mips_pkg::data_width-1:0]        debug_data
);

	logic [mips_pkg::data_width-1:0] regs [2**mips_pkg::reg_addr_width];

	// r0 reads zero, same-cycle write wins over stored value
	function automatic logic [mips_pkg::data_width-1:0] read_port(
		input logic [mips_pkg::reg_addr_width-1:0] addr
	);
		if (addr == '0) return '0;
		if (wr_en && wr_addr == addr) return wr_data;
		return regs[addr];
	endfunction

	always_comb begin
		rd1_data = read_port(rd1_addr);
		rd2_data = read_port(rd2_addr);
	end

	assign debug_data = regs[debug_addr]; // stored state, no bypass

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**mips_pkg::reg_addr_width; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage: pc, instruction memory with load
// port, redirect handling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module fetch_stage (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    run,
	input  logic                                    imem_we,
	input  logic [mips_pkg::imem_addr_width-1:0]    imem_addr,
	input  logic [mips_pkg::data_width-1:0]         imem_wdata,
	input  logic                                    redirect,
	input  logic [mips_pkg::data_width-1:0]         redirect_pc,
	output logic                                    if_valid,
	output logic [mips_pkg::data_width-1:0]         if_pc,
	output logic [mips_pkg::data_width-1:0]         if_instr
);

	logic [mips_pkg::data_width-1:0] imem [2**mips_pkg::imem_addr_width];
	logic [mips_pkg::data_width-1:0] pc; // word address
	logic [mips_pkg::imem_addr_width-1:0] pc_index;

	assign pc_index = pc[mips_pkg::imem_addr_width-1:0];

	// memory: load port and registered read
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
		if_instr <= imem[pc_index];
		if_pc    <= pc + 1'b1; // next_pc travels with the instruction
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc       <= '0;
			if_valid <= 1'b0;
		end else if (redirect) begin
			// taken branch, drop the fetch in flight
			pc       <= redirect_pc;
			if_valid <= 1'b0;
		end else if (run) begin
			pc       <= pc + 1'b1;
			if_valid <= 1'b1;
		end else begin
			if_valid <= 1'b0; // paused, pc holds
		end
	end

	// branch targets come from decode arithmetic, so an out-of-range
	// offset would silently alias into the memory
	a_redirect_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		redirect |-> redirect_pc[mips_pkg::data_width-1:mips_pkg::imem_addr_width] == '0
	);

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage with field split, control decode,
// operand forwarding and the ID/EX register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module decode_stage (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   if_valid,
	input  logic [mips_pkg::data_width-1:0]        if_pc,
	input  logic [mips_pkg::data_width-1:0]        if_instr,
	input  logic                                   squash,
	input  logic [mips_pkg::data_width-1:0]        rf_data1,
	input  logic [mips_pkg::data_width-1:0]        rf_data2,
	input  logic                                   ex_valid,
	input  logic [mips_pkg::reg_addr_width-1:0]    ex_dest,
	input  logic [mips_pkg::data_width-1:0]        ex_result,
	input  logic                                   wb_en,
	input  logic [mips_pkg::reg_addr_width-1:0]    wb_addr,
	input  logic [mips_pkg::data_width-1:0]        wb_data,
	output logic [mips_pkg::reg_addr_width-1:0]    rf_addr1,
	output logic [mips_pkg::reg_addr_width-1:0]    rf_addr2,
	output logic                                   id_valid,
	output logic [mips_pkg::data_width-1:0]        id_a,
	output logic [mips_pkg::data_width-1:0]        id_b,
	output mips_pkg::alu_op_t                      id_alu_op,
	output logic [4:0]                             id_shamt,
	output logic [mips_pkg::reg_addr_width-1:0]    id_dest,
	output mips_pkg::branch_op_t                   id_branch_op,
	output logic [mips_pkg::data_width-1:0]        id_branch_target
);

	logic [5:0] opcode;
	logic [5:0] func;
	logic [mips_pkg::reg_addr_width-1:0] rs;
	logic [mips_pkg::reg_addr_width-1:0] rt;
	logic [mips_pkg::reg_addr_width-1:0] rd;
	logic [4:0] sa;
	logic [15:0] imm;
	logic [mips_pkg::data_width-1:0] imm_ext;

	mips_pkg::alu_op_t alu_op;
	mips_pkg::alu_src_t alu_src;
	mips_pkg::branch_op_t branch_op;
	logic [mips_pkg::reg_addr_width-1:0] dest;
	logic [mips_pkg::data_width-1:0] opnd_a;
	logic [mips_pkg::data_width-1:0] opnd_b;
	logic [mips_pkg::data_width-1:0] reg_b;

	assign opcode  = if_instr[31:mips_pkg::opcode_lsb];
	assign rs      = if_instr[mips_pkg::rs_lsb +: mips_pkg::reg_addr_width];
	assign rt      = if_instr[mips_pkg::rt_lsb +: mips_pkg::reg_addr_width];
	assign rd      = if_instr[mips_pkg::rd_lsb +: mips_pkg::reg_addr_width];
	assign sa      = if_instr[mips_pkg::sa_lsb +: 5];
	assign func    = if_instr[5:0];
	assign imm     = if_instr[15:0];
	assign imm_ext = {{(mips_pkg::data_width-16){imm[15]}}, imm};

	assign rf_addr1 = rs;
	assign rf_addr2 = rt;

	always_comb begin
		alu_op    = mips_pkg::alu_none;
		alu_src   = mips_pkg::src_reg;
		branch_op = mips_pkg::br_none;
		dest      = '0;
		case (opcode)
			mips_pkg::op_rtype: begin
				dest = rd;
				case (func)
					mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
					mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
					default:           dest = '0; // unknown func is a no-op
				endcase
			end
			mips_pkg::op_addiu: begin
				alu_op  = mips_pkg::alu_add;
				alu_src = mips_pkg::src_imm;
				dest    = rt;
			end
			mips_pkg::op_beq: begin
				alu_op    = mips_pkg::alu_sub; // zero difference means taken
				branch_op = mips_pkg::br_beq;
			end
			default: ; // unknown opcode decodes as no-op
		endcase
	end

	// youngest producer wins with EX ahead of WB ahead of the file
	function automatic logic [mips_pkg::data_width-1:0] forward(
		input logic [mips_pkg::reg_addr_width-1:0] addr,
		input logic [mips_pkg::data_width-1:0] rf_val
	);
		if (addr == '0) return '0;
		if (ex_valid && ex_dest == addr) return ex_result;
		if (wb_en && wb_addr == addr) return wb_data;
		return rf_val;
	endfunction

	always_comb begin
		opnd_a = forward(rs, rf_data1);
		reg_b  = forward(rt, rf_data2);
		opnd_b = (alu_src == mips_pkg::src_imm) ? imm_ext : reg_b;
	end

	// ID/EX control
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_valid     <= 1'b0;
			id_alu_op    <= mips_pkg::alu_none;
			id_branch_op <= mips_pkg::br_none;
			id_dest      <= '0;
		end else begin
			id_valid     <= if_valid && !squash; // younger slot killed on redirect
			id_alu_op    <= alu_op;
			id_branch_op <= branch_op;
			id_dest      <= dest;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		id_a             <= opnd_a;
		id_b             <= opnd_b;
		id_shamt         <= sa;
		id_branch_target <= if_pc + imm_ext; // next_pc plus offset in words
	end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage with ALU, BEQ resolution and the
// EX/WB retire register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module execute_stage (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   id_valid,
	input  logic [mips_pkg::data_width-1:0]        id_a,
	input  logic [mips_pkg::data_width-1:0]        id_b,
	input  mips_pkg::alu_op_t                      id_alu_op,
	input  logic [4:0]                             id_shamt,
	input  logic [mips_pkg::reg_addr_width-1:0]    id_dest,
	input  mips_pkg::branch_op_t                   id_branch_op,
	input  logic [mips_pkg::data_width-1:0]        id_branch_target,
	output logic                                   ex_valid,
	output logic [mips_pkg::reg_addr_width-1:0]    ex_dest,
	output logic [mips_pkg::data_width-1:0]        ex_result,
	output logic                                   redirect,
	output logic [mips_pkg::data_width-1:0]        redirect_pc,
	output logic                                   wb_en,
	output logic [mips_pkg::reg_addr_width-1:0]    wb_addr,
	output logic [mips_pkg::data_width-1:0]        wb_data
);

	logic [mips_pkg::data_width-1:0] alu_result;
	logic slt_bit;

	assign slt_bit = $signed(id_a) < $signed(id_b);

	always_comb begin
		case (id_alu_op)
			mips_pkg::alu_add: alu_result = id_a + id_b;
			mips_pkg::alu_sub: alu_result = id_a - id_b;
			mips_pkg::alu_and: alu_result = id_a & id_b;
			mips_pkg::alu_or:  alu_result = id_a | id_b;
			mips_pkg::alu_xor: alu_result = id_a ^ id_b;
			mips_pkg::alu_slt: alu_result = {{(mips_pkg::data_width-1){1'b0}}, slt_bit};
			mips_pkg::alu_sll: alu_result = id_b << id_shamt;
			default:           alu_result = '0;
		endcase
	end

	// forwarding source for the instruction now in decode
	assign ex_valid  = id_valid;
	assign ex_dest   = id_dest;
	assign ex_result = alu_result;

	assign redirect    = id_valid && id_branch_op == mips_pkg::br_beq && alu_result == '0;
	assign redirect_pc = id_branch_target;

	// EX/WB register doubles as the retire port
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_en <= 1'b0;
		end else begin
			wb_en <= id_valid && id_dest != '0;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr <= id_dest;
		wb_data <= alu_result;
	end

	// decode must have squashed the slot behind a taken branch
	a_redirect_squash: assert property (
		@(posedge clk) disable iff (!rst_n)
		redirect |=> !id_valid
	);

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core top: fetch, decode, register file, execute
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module core_top (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   run,
	input  logic                                   imem_we,
	input  logic [mips_pkg::imem_addr_width-1:0]   imem_addr,
	input  logic [mips_pkg::data_width-1:0]        imem_wdata,
	input  logic [mips_pkg::reg_addr_width-1:0]    debug_addr,
	output logic                                   retire_valid,
	output logic [mips_pkg::reg_addr_width-1:0]    retire_addr,
	output logic [mips_pkg::data_width-1:0]        retire_data,
	output logic [mips_pkg::data_width-1:0]        debug_data
);

	// fetch to decode
	logic if_valid;
	logic [mips_pkg::data_width-1:0] if_pc;
	logic [mips_pkg::data_width-1:0] if_instr;

	// register file read ports
	logic [mips_pkg::reg_addr_width-1:0] rf_addr1;
	logic [mips_pkg::reg_addr_width-1:0] rf_addr2;
	logic [mips_pkg::data_width-1:0] rf_data1;
	logic [mips_pkg::data_width-1:0] rf_data2;

	// decode to execute
	logic id_valid;
	logic [mips_pkg::data_width-1:0] id_a;
	logic [mips_pkg::data_width-1:0] id_b;
	mips_pkg::alu_op_t id_alu_op;
	logic [4:0] id_shamt;
	logic [mips_pkg::reg_addr_width-1:0] id_dest;
	mips_pkg::branch_op_t id_branch_op;
	logic [mips_pkg::data_width-1:0] id_branch_target;

	// execute back to the other stages
	logic ex_valid;
	logic [mips_pkg::reg_addr_width-1:0] ex_dest;
	logic [mips_pkg::data_width-1:0] ex_result;
	logic redirect;
	logic [mips_pkg::data_width-1:0] redirect_pc;
	logic wb_en;
	logic [mips_pkg::reg_addr_width-1:0] wb_addr;
	logic [mips_pkg::data_width-1:0] wb_data;

	fetch_stage i_fetch_stage (
		.clk, .rst_n, .run, .imem_we, .imem_addr, .imem_wdata,
		.redirect, .redirect_pc, .if_valid, .if_pc, .if_instr
	);

	decode_stage i_decode_stage (
		.clk, .rst_n, .if_valid, .if_pc, .if_instr,
		.squash(redirect), // same pulse that restarts fetch
		.rf_data1, .rf_data2, .ex_valid, .ex_dest, .ex_result,
		.wb_en, .wb_addr, .wb_data, .rf_addr1, .rf_addr2,
		.id_valid, .id_a, .id_b, .id_alu_op, .id_shamt, .id_dest,
		.id_branch_op, .id_branch_target
	);

	register_file i_register_file (
		.clk, .rst_n,
		.rd1_addr(rf_addr1), .rd2_addr(rf_addr2),
		.wr_en(wb_en), .wr_addr(wb_addr), .wr_data(wb_data),
		.debug_addr, .rd1_data(rf_data1), .rd2_data(rf_data2), .debug_data
	);

	execute_stage i_execute_stage (
		.clk, .rst_n, .id_valid, .id_a, .id_b, .id_alu_op, .id_shamt,
		.id_dest, .id_branch_op, .id_branch_target,
		.ex_valid, .ex_dest, .ex_result, .redirect, .redirect_pc,
		.wb_en, .wb_addr, .wb_data
	);

	// retire is the writeback port
	assign retire_valid = wb_en;
	assign retire_addr  = wb_addr;
	assign retire_data  = wb_data;

endmodule

`default_nettype wire

// ==== test/isa_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequential ISA model and instruction encoders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// beq r0, r0, -1 branches onto itself
localparam logic [31:0] halt_word = {mips_pkg::op_beq, 10'd0, 16'hffff};

logic [31:0] prog [64];
logic [4:0]  exp_addr [$]; // expected retire stream, oldest first
logic [31:0] exp_data [$];
logic [31:0] model_regs [32];

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
	input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
	return {mips_pkg::op_rtype, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// unused words hold an undefined opcode tagged with their address
function automatic void clear_prog();
	for (int a = 0; a < 64; a++) begin
		prog[a] = {6'h3f, 26'(a)};
	end
endfunction

// runs prog in order up to the halt loop, -1 if it never gets there
function automatic int run_model();
	logic [31:0] r [32];
	logic [31:0] pc;
	logic [31:0] ins;
	logic [31:0] simm;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] res;
	logic [4:0] dest;
	logic wr;
	exp_addr.delete();
	exp_data.delete();
	for (int i = 0; i < 32; i++) begin
		r[i] = '0;
	end
	pc = '0;
	for (int step = 0; step < 4000; step++) begin
		ins  = prog[pc[5:0]];
		simm = {{16{ins[15]}}, ins[15:0]};
		a    = r[ins[25:21]];
		b    = r[ins[20:16]];
		wr   = 1'b0;
		dest = ins[15:11];
		res  = '0;
		case (ins[31:26])
			mips_pkg::op_rtype: begin
				wr = 1'b1;
				case (ins[5:0])
					mips_pkg::fn_addu: res = a + b;
					mips_pkg::fn_subu: res = a - b;
					mips_pkg::fn_and:  res = a & b;
					mips_pkg::fn_or:   res = a | b;
					mips_pkg::fn_xor:  res = a ^ b;
					mips_pkg::fn_slt:  res = {31'd0, $signed(a) < $signed(b)};
					mips_pkg::fn_sll:  res = b << ins[10:6];
					default:           wr = 1'b0;
				endcase
			end
			mips_pkg::op_addiu: begin
				wr   = 1'b1;
				dest = ins[20:16];
				res  = a + simm;
			end
			mips_pkg::op_beq: begin
				if (a == b) begin
					if (pc + 32'd1 + simm == pc) begin
						model_regs = r;
						return step;
					end
					pc = pc + simm;
				end
			end
			default: ; // undefined opcode, nothing happens
		endcase
		if (wr && dest != 5'd0) begin
			r[dest] = res;
			exp_addr.push_back(dest);
			exp_data.push_back(res);
		end
		pc = pc + 32'd1;
	end
	return -1;
endfunction

`endif

// ==== test/core_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core testbench with program load, retire stream
// and final register compare against the ISA model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rst_n;
	logic run;
	logic imem_we;
	logic [mips_pkg::imem_addr_width-1:0] imem_addr;
	logic [mips_pkg::data_width-1:0] imem_wdata;
	logic [mips_pkg::reg_addr_width-1:0] debug_addr;
	logic retire_valid;
	logic [mips_pkg::reg_addr_width-1:0] retire_addr;
	logic [mips_pkg::data_width-1:0] retire_data;
	logic [mips_pkg::data_width-1:0] debug_data;

	int check_count = 0;
	int value_errors = 0;
	int other_errors = 0;
	int retired = 0; // retires seen since time 0

	`include "isa_model.svh"

	core_top i_core_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] got,
		input logic [31:0] want);
		check_count++;
		if (got !== want) begin
			value_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	// every retire pops the next expected write
	initial begin
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && retire_valid === 1'b1) begin
				retired++;
				if (exp_addr.size() == 0) begin
					other_errors++;
					$display("retire to r%0d at %0t with no write expected",
						retire_addr, $time);
				end else begin
					check("retire_addr", 32'(retire_addr), 32'(exp_addr[0]));
					check("retire_data", retire_data, exp_data[0]);
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
				end
			end
		end
	end

	// whole memory is written under reset followed by 4 more reset cycles
	task automatic load_program();
		@(posedge clk);
		rst_n <= 1'b0;
		run   <= 1'b0;
		for (int a = 0; a < 64; a++) begin
			@(posedge clk);
			imem_we    <= 1'b1;
			imem_addr  <= 6'(a);
			imem_wdata <= prog[a];
		end
		@(posedge clk);
		imem_we <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic run_program(input string name, input logic toggle_run);
		int want;
		int start;
		int cycles;
		if (run_model() < 0) begin
			other_errors++;
			$display("%s: the model never reached the halt loop", name);
			return;
		end
		want = exp_addr.size();
		load_program();
		start  = retired;
		cycles = 0;
		while (retired - start < want && cycles < 3000) begin
			@(posedge clk);
			run <= toggle_run ? (($urandom % 3) != 0) : 1'b1;
			cycles++;
		end
		if (retired - start < want) begin
			other_errors++;
			$display("%s: timed out with %0d of %0d writes retired",
				name, retired - start, want);
		end
		@(posedge clk);
		run <= 1'b1;
		repeat (16) @(posedge clk); // any stray retire while spinning on the halt shows up here
		for (int i = 0; i < 32; i++) begin
			@(posedge clk);
			debug_addr <= 5'(i);
			@(negedge clk);
			check($sformatf("debug_data r%0d", i), debug_data, model_regs[i]);
		end
	endtask

	task automatic build_arith();
		clear_prog();
		for (int i = 0; i < 6; i++) begin
			prog[i] = enc_i(mips_pkg::op_addiu, 5'd0, 5'(i + 1), 16'($urandom));
		end
		prog[4][15] = 1'b1; // r5 negative and r6 positive for signed slt
		prog[5][15] = 1'b0;
		prog[6]  = enc_r(5'd1, 5'd2, 5'd7, 5'd0, mips_pkg::fn_addu);
		prog[7]  = enc_r(5'd3, 5'd4, 5'd8, 5'd0, mips_pkg::fn_subu);
		prog[8]  = enc_r(5'd5, 5'd6, 5'd9, 5'd0, mips_pkg::fn_and);
		prog[9]  = enc_r(5'd1, 5'd3, 5'd10, 5'd0, mips_pkg::fn_or);
		prog[10] = enc_r(5'd2, 5'd4, 5'd11, 5'd0, mips_pkg::fn_xor);
		prog[11] = enc_r(5'd5, 5'd6, 5'd12, 5'd0, mips_pkg::fn_slt);
		prog[12] = enc_r(5'd6, 5'd5, 5'd13, 5'd0, mips_pkg::fn_slt);
		prog[13] = enc_r(5'd0, 5'd1, 5'd14, 5'($urandom), mips_pkg::fn_sll);
		prog[14] = halt_word;
	endtask

	// instruction i reads the two previous destinations
	task automatic build_chain();
		clear_prog();
		prog[0] = enc_i(mips_pkg::op_addiu, 5'd0, 5'd1, 16'($urandom));
		prog[1] = enc_i(mips_pkg::op_addiu, 5'd0, 5'd2, 16'($urandom));
		for (int i = 2; i < 20; i++) begin
			prog[i] = enc_r(5'(i - 1), 5'(i), 5'(i + 1), 5'd0,
				(i % 3 == 0) ? mips_pkg::fn_addu :
				(i % 3 == 1) ? mips_pkg::fn_subu : mips_pkg::fn_xor);
		end
		prog[20] = halt_word;
	endtask

	task automatic build_branches();
		clear_prog();
		prog[0]  = enc_i(mips_pkg::op_addiu, 5'd0, 5'd1, 16'd5); // loop count
		prog[1]  = enc_i(mips_pkg::op_addiu, 5'd0, 5'd2, 16'd0);
		prog[2]  = enc_i(mips_pkg::op_addiu, 5'd2, 5'd2, 16'd7);
		prog[3]  = enc_i(mips_pkg::op_addiu, 5'd1, 5'd1, 16'hffff);
		prog[4]  = enc_i(mips_pkg::op_beq, 5'd1, 5'd0, 16'd1); // exit when done
		prog[5]  = enc_i(mips_pkg::op_beq, 5'd0, 5'd0, 16'hfffc); // back to 2
		prog[6]  = enc_i(mips_pkg::op_beq, 5'd2, 5'd0, 16'd2); // not taken
		prog[7]  = enc_i(mips_pkg::op_addiu, 5'd0, 5'd4, 16'h0011);
		prog[8]  = enc_i(mips_pkg::op_beq, 5'd4, 5'd4, 16'd2);
		prog[9]  = enc_i(mips_pkg::op_addiu, 5'd0, 5'd5, 16'h0022);
		prog[10] = enc_i(mips_pkg::op_addiu, 5'd0, 5'd6, 16'h0033);
		prog[11] = enc_i(mips_pkg::op_addiu, 5'd4, 5'd7, 16'd1);
		prog[12] = halt_word;
	endtask

	task automatic build_reg0();
		clear_prog();
		prog[0] = enc_i(mips_pkg::op_addiu, 5'd0, 5'd1, 16'h1234);
		prog[1] = enc_i(mips_pkg::op_addiu, 5'd0, 5'd0, 16'h0055);
		prog[2] = enc_r(5'd0, 5'd1, 5'd2, 5'd0, mips_pkg::fn_addu); // reads r0 right behind its write
		prog[3] = {6'h3e, 26'h3ffffff}; // undefined opcode
		prog[4] = enc_r(5'd1, 5'd1, 5'd3, 5'd0, 6'h3f); // undefined func
		prog[5] = enc_r(5'd1, 5'd1, 5'd0, 5'd0, mips_pkg::fn_addu);
		prog[6] = halt_word;
	endtask

	// forward branches only so every program reaches the halt
	task automatic build_random(input int len);
		int kind;
		int off;
		logic [5:0] fn;
		clear_prog();
		for (int i = 0; i < len; i++) begin
			kind = int'($urandom % 10);
			case ($urandom % 7)
				0: fn = mips_pkg::fn_addu;
				1: fn = mips_pkg::fn_subu;
				2: fn = mips_pkg::fn_and;
				3: fn = mips_pkg::fn_or;
				4: fn = mips_pkg::fn_xor;
				5: fn = mips_pkg::fn_slt;
				default: fn = mips_pkg::fn_sll;
			endcase
			if (kind < 3) begin
				prog[i] = enc_i(mips_pkg::op_addiu, 5'($urandom % 8), 5'($urandom % 8),
					16'($urandom));
			end else if (kind < 9) begin
				prog[i] = enc_r(5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8),
					5'($urandom), fn);
			end else begin
				off = int'($urandom % 4);
				if (i + 1 + off > len) off = len - i - 1;
				prog[i] = enc_i(mips_pkg::op_beq, 5'($urandom % 8), 5'($urandom % 8),
					16'(off));
			end
		end
		prog[len] = halt_word;
	endtask

	initial begin
		void'($urandom(72));
		rst_n      = 1'b0;
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		debug_addr = '0;
		build_arith();
		run_program("arith", 1'b0);
		build_chain();
		run_program("chain", 1'b0);
		build_branches();
		run_program("branches", 1'b0);
		build_reg0();
		run_program("reg0", 1'b0);
		for (int n = 0; n < 4; n++) begin
			build_random(24 + 8 * n);
			run_program($sformatf("random %0d", n), 1'b1);
		end
		$display("checks %0d, value errors %0d, other errors %0d",
			check_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+test
design/mips_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/core_top.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f vlog.f --top-module core_tb -o core_sim
./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then
	exit 1
fi
exit 0
